// ==== rtl/wb_stream_pkg.sv ====
package wb_stream_pkg;

   // Register map, one 32-bit word per address
   localparam logic [1:0] ADR_TX_DATA = 2'd0;
   localparam logic [1:0] ADR_RX_DATA = 2'd1;
   localparam logic [1:0] ADR_STATUS  = 2'd2;
   localparam logic [1:0] ADR_PERIOD  = 2'd3;

   // Status register bit positions
   localparam int unsigned ST_TX_EMPTY  = 0;
   localparam int unsigned ST_TX_FULL   = 1;
   localparam int unsigned ST_RX_EMPTY  = 2;
   localparam int unsigned ST_RX_FULL   = 3;
   localparam int unsigned ST_OVERFLOW  = 4;
   localparam int unsigned ST_UNDERFLOW = 5;
   localparam int unsigned ST_RX_ERR    = 6;

   // Wishbone classic request from the host
   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        we;
      logic [1:0]  adr;
      logic [31:0] dat;
   } wb_req_t;

   // Wishbone classic response to the host
   typedef struct packed {
      logic        ack;
      logic [31:0] dat;
   } wb_rsp_t;

   // Transmit entry, tag is a running sequence number
   typedef struct packed {
      logic [31:0] data;
      logic [3:0]  tag;
   } tx_entry_t;

   // Receive entry, err comes from the input stream
   typedef struct packed {
      logic [31:0] data;
      logic        err;
   } rx_entry_t;

endpackage

// ==== rtl/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
   parameter int  FIFO_DEPTH = 16,
   parameter type PAYLOAD_T  = logic [31:0]
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     push,
   input  logic     pop,
   input  PAYLOAD_T din,
   output PAYLOAD_T dout,
   output logic     empty,
   output logic     full
);

   localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CW = AW + 1;

   PAYLOAD_T        mem [FIFO_DEPTH];
   logic [AW-1:0]   wr_ptr;
   logic [AW-1:0]   rd_ptr;
   logic [CW-1:0]   count;
   logic            wr_en;
   logic            rd_en;

   // Requests past the flags are ignored
   assign wr_en = push && !full;
   assign rd_en = pop && !empty;

   assign empty = (count == '0);
   assign full  = (count == CW'(FIFO_DEPTH));

   // Occupancy, unchanged on a simultaneous push and pop
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         count <= '0;
      end
      else
      begin
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Pointers wrap at the depth, which need not be a power of two
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (wr_en)
         begin
            wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (rd_en)
         begin
            rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
      end
   end

   // Storage
   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         mem[wr_ptr] <= din;
      end
   end

   // Read data is registered, valid the cycle after the pop
   always_ff @(posedge clk)
   begin
      if (rd_en)
      begin
         dout <= mem[rd_ptr];
      end
   end

   a_count_bound : assert property (
      @(posedge clk) disable iff (rst)
      count <= CW'(FIFO_DEPTH)
   );

endmodule

// ==== rtl/pace_timer.sv ====
`timescale 1ns/1ps

module pace_timer #(
   parameter int PERIOD_W = 8
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                load,
   input  logic [PERIOD_W-1:0] period,
   output logic                expired
);

   logic [PERIOD_W-1:0] count;

   // Load on a transfer, then count down and stop at zero
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         count <= '0;
      end
      else if (load)
      begin
         count <= period;
      end
      else if (count != '0)
      begin
         count <= count - 1'b1;
      end
   end

   // A reload with a nonzero period ends the expired state on the same edge,
   // so the drain cannot pop alongside a transfer unless the period is 0
   assign expired = (count == '0) && (!load || (period == '0));

   // The drain always leaves a gap cycle after each transfer
   a_no_back_to_back_load : assert property (
      @(posedge clk) disable iff (rst)
      load |=> !load
   );

endmodule

// ==== rtl/tx_drain.sv ====
`timescale 1ns/1ps

module tx_drain (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    fifo_empty,
   input  wb_stream_pkg::tx_entry_t fifo_dout,
   output logic                    fifo_pop,
   input  logic                    timer_expired,
   output logic                    timer_load,
   output logic                    out_valid,
   output logic [31:0]             out_data,
   output logic [3:0]              out_tag,
   input  logic                    out_ready
);

   wb_stream_pkg::tx_entry_t hold;
   logic                     held;
   logic                     pending;
   logic                     transfer;

   assign transfer = held && out_ready;

   // Pop only into a free slot, with no read already in flight
   assign fifo_pop = !fifo_empty && timer_expired && !pending && (!held || transfer);

   assign timer_load = transfer;

   // pending marks the cycle where the FIFO dout holds the popped word
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pending <= 1'b0;
         held    <= 1'b0;
      end
      else
      begin
         pending <= fifo_pop;
         if (pending)
         begin
            held <= 1'b1;
         end
         else if (transfer)
         begin
            held <= 1'b0;
         end
      end
   end

   // Output word register
   always_ff @(posedge clk)
   begin
      if (pending)
      begin
         hold <= fifo_dout;
      end
   end

   assign out_valid = held;
   assign out_data  = hold.data;
   assign out_tag   = hold.tag;

   a_hold_stable : assert property (
      @(posedge clk) disable iff (rst)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
   );

endmodule

// ==== rtl/wb_bus_fsm.sv ====
`timescale 1ns/1ps

module wb_bus_fsm #(
   parameter int PERIOD_W = 8
) (
   input  logic                     clk,
   input  logic                     rst,
   input  wb_stream_pkg::wb_req_t   bus_req,
   output wb_stream_pkg::wb_rsp_t   bus_rsp,
   output logic                     tx_push,
   output wb_stream_pkg::tx_entry_t tx_din,
   input  logic                     tx_full,
   input  logic                     tx_empty,
   output logic                     rx_pop,
   input  wb_stream_pkg::rx_entry_t rx_dout,
   input  logic                     rx_empty,
   input  logic                     rx_full,
   input  logic                     rx_drop,
   output logic [PERIOD_W-1:0]      period
);

   import wb_stream_pkg::*;

   typedef enum logic [1:0] {
      IDLE,
      RX_WAIT,
      ACK
   } state_t;

   state_t              state;
   logic                req_valid;
   logic                tx_wr;
   logic                rx_rd;
   logic                st_wr;
   logic                per_wr;
   logic [3:0]          seq;
   logic                ovf;
   logic                udf;
   logic                last_err;
   logic [PERIOD_W-1:0] period_q;
   logic [31:0]         status_word;
   logic [31:0]         rdata;

   // A new request is only taken in IDLE
   assign req_valid = (state == IDLE) && bus_req.cyc && bus_req.stb;

   assign tx_wr  = req_valid && bus_req.we && (bus_req.adr == ADR_TX_DATA);
   assign st_wr  = req_valid && bus_req.we && (bus_req.adr == ADR_STATUS);
   assign per_wr = req_valid && bus_req.we && (bus_req.adr == ADR_PERIOD);
   assign rx_rd  = req_valid && !bus_req.we && (bus_req.adr == ADR_RX_DATA);

   assign tx_push = tx_wr && !tx_full;
   assign rx_pop  = rx_rd && !rx_empty;

   assign tx_din.data = bus_req.dat;
   assign tx_din.tag  = seq;

   always_comb
   begin
      status_word               = '0;
      status_word[ST_TX_EMPTY]  = tx_empty;
      status_word[ST_TX_FULL]   = tx_full;
      status_word[ST_RX_EMPTY]  = rx_empty;
      status_word[ST_RX_FULL]   = rx_full;
      status_word[ST_OVERFLOW]  = ovf;
      status_word[ST_UNDERFLOW] = udf;
      status_word[ST_RX_ERR]    = last_err;
   end

   // Receive reads wait one extra cycle for the FIFO read data
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state <= IDLE;
      end
      else
      begin
         case (state)
            IDLE:
            begin
               if (req_valid)
               begin
                  state <= rx_pop ? RX_WAIT : ACK;
               end
            end
            RX_WAIT: state <= ACK;
            default: state <= IDLE;
         endcase
      end
   end

   // Control registers and sticky errors
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         period_q <= '0;
         seq      <= '0;
         ovf      <= 1'b0;
         udf      <= 1'b0;
         last_err <= 1'b0;
      end
      else
      begin
         if (per_wr)
         begin
            period_q <= bus_req.dat[PERIOD_W-1:0];
         end
         if (tx_push)
         begin
            seq <= seq + 1'b1;
         end
         // Setting wins over a clear in the same cycle
         if ((tx_wr && tx_full) || rx_drop)
         begin
            ovf <= 1'b1;
         end
         else if (st_wr && bus_req.dat[ST_OVERFLOW])
         begin
            ovf <= 1'b0;
         end
         if (rx_rd && rx_empty)
         begin
            udf <= 1'b1;
         end
         else if (st_wr && bus_req.dat[ST_UNDERFLOW])
         begin
            udf <= 1'b0;
         end
         if (state == RX_WAIT)
         begin
            last_err <= rx_dout.err;
         end
      end
   end

   // Read data, zero for an empty receive FIFO or a write-only register
   always_ff @(posedge clk)
   begin
      if (state == RX_WAIT)
      begin
         rdata <= rx_dout.data;
      end
      else if (req_valid && !bus_req.we)
      begin
         case (bus_req.adr)
            ADR_STATUS: rdata <= status_word;
            ADR_PERIOD: rdata <= 32'(period_q);
            default:    rdata <= '0;
         endcase
      end
   end

   assign bus_rsp.ack = (state == ACK);
   assign bus_rsp.dat = rdata;
   assign period      = period_q;

   a_ack_single : assert property (
      @(posedge clk) disable iff (rst)
      bus_rsp.ack |=> !bus_rsp.ack
   );

endmodule

// ==== rtl/wb_stream_bridge.sv ====
`timescale 1ns/1ps

module wb_stream_bridge #(
   parameter int FIFO_DEPTH = 16,
   parameter int PERIOD_W   = 8
) (
   input  logic                   clk,
   input  logic                   rst,
   input  wb_stream_pkg::wb_req_t bus_req,
   output wb_stream_pkg::wb_rsp_t bus_rsp,
   input  logic                   in_valid,
   input  logic [31:0]            in_data,
   input  logic                   in_err,
   output logic                   out_valid,
   output logic [31:0]            out_data,
   output logic [3:0]             out_tag,
   input  logic                   out_ready
);

   import wb_stream_pkg::*;

   tx_entry_t           tx_din;
   tx_entry_t           tx_dout;
   logic                tx_push;
   logic                tx_pop;
   logic                tx_empty;
   logic                tx_full;
   rx_entry_t           rx_din;
   rx_entry_t           rx_dout;
   logic                rx_pop;
   logic                rx_empty;
   logic                rx_full;
   logic                rx_drop;
   logic [PERIOD_W-1:0] period;
   logic                timer_load;
   logic                timer_expired;

   // Input stream has no back-pressure, a word into a full FIFO is lost
   assign rx_din.data = in_data;
   assign rx_din.err  = in_err;
   assign rx_drop     = in_valid && rx_full;

   wb_bus_fsm #(
      .PERIOD_W (PERIOD_W)
   ) bus_fsm_i (
      .clk      (clk),
      .rst      (rst),
      .bus_req  (bus_req),
      .bus_rsp  (bus_rsp),
      .tx_push  (tx_push),
      .tx_din   (tx_din),
      .tx_full  (tx_full),
      .tx_empty (tx_empty),
      .rx_pop   (rx_pop),
      .rx_dout  (rx_dout),
      .rx_empty (rx_empty),
      .rx_full  (rx_full),
      .rx_drop  (rx_drop),
      .period   (period)
   );

   sync_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH),
      .PAYLOAD_T  (tx_entry_t)
   ) tx_fifo_i (
      .clk   (clk),
      .rst   (rst),
      .push  (tx_push),
      .pop   (tx_pop),
      .din   (tx_din),
      .dout  (tx_dout),
      .empty (tx_empty),
      .full  (tx_full)
   );

   sync_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH),
      .PAYLOAD_T  (rx_entry_t)
   ) rx_fifo_i (
      .clk   (clk),
      .rst   (rst),
      .push  (in_valid),
      .pop   (rx_pop),
      .din   (rx_din),
      .dout  (rx_dout),
      .empty (rx_empty),
      .full  (rx_full)
   );

   pace_timer #(
      .PERIOD_W (PERIOD_W)
   ) pace_timer_i (
      .clk     (clk),
      .rst     (rst),
      .load    (timer_load),
      .period  (period),
      .expired (timer_expired)
   );

   tx_drain tx_drain_i (
      .clk           (clk),
      .rst           (rst),
      .fifo_empty    (tx_empty),
      .fifo_dout     (tx_dout),
      .fifo_pop      (tx_pop),
      .timer_expired (timer_expired),
      .timer_load    (timer_load),
      .out_valid     (out_valid),
      .out_data      (out_data),
      .out_tag       (out_tag),
      .out_ready     (out_ready)
   );

endmodule

// ==== tests/wb_stream_bridge_tb.sv ====
`timescale 1ns/1ps

module wb_stream_bridge_tb;

   import wb_stream_pkg::*;

   localparam int FIFO_DEPTH    = 16;
   localparam int PERIOD_W      = 8;
   localparam int BUS_TIMEOUT   = 20;
   localparam int DRAIN_TIMEOUT = 10000;

   logic        clk;
   logic        rst;
   wb_req_t     bus_req;
   wb_rsp_t     bus_rsp;
   logic        in_valid;
   logic [31:0] in_data;
   logic        in_err;
   logic        out_valid;
   logic [31:0] out_data;
   logic [3:0]  out_tag;
   logic        out_ready = 1'b0;

   integer        seed;
   int            errors;
   int            mon_errors;
   int            abort;
   int            cur_test;
   int            test_start_errors;
   int            tests_run;
   int            tests_failed;
   int            min_gap;
   int            gap_epoch;

   // Expected output words packed as {data, tag}
   logic [35:0]   exp_q[$];
   logic [35:0]   exp_word;

   // Monitor state
   int            cycle;
   int            last_rise;
   int            rise_epoch;
   logic          prev_valid;
   logic          prev_ready;
   logic [31:0]   prev_data;
   logic [3:0]    prev_tag;

   // File parsing
   int            fd;
   int            code;
   int            tnum;
   logic [7:0]    cmd;
   logic [31:0]   arg_a;
   logic [31:0]   arg_b;
   int            count;
   logic [1023:0] line;

   wb_stream_bridge #(
      .FIFO_DEPTH (FIFO_DEPTH),
      .PERIOD_W   (PERIOD_W)
   ) dut_i (
      .clk       (clk),
      .rst       (rst),
      .bus_req   (bus_req),
      .bus_rsp   (bus_rsp),
      .in_valid  (in_valid),
      .in_data   (in_data),
      .in_err    (in_err),
      .out_valid (out_valid),
      .out_data  (out_data),
      .out_tag   (out_tag),
      .out_ready (out_ready)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Roughly one cycle in three with the sink stalled
   always @(posedge clk)
   begin
      if (rst)
      begin
         out_ready <= 1'b0;
      end
      else
      begin
         out_ready <= ($unsigned($random(seed)) % 3) != 0;
      end
   end

   // Output stream monitor for order, back-pressure hold and pacing
   always @(posedge clk)
   begin
      if (rst)
      begin
         cycle      = 0;
         last_rise  = 0;
         rise_epoch = -1;
         prev_valid = 1'b0;
         prev_ready = 1'b0;
      end
      else
      begin
         cycle = cycle + 1;
         if (prev_valid && !prev_ready)
         begin
            if (!out_valid)
            begin
               $display("test %0d: out_valid dropped before its word transferred", cur_test);
               mon_errors = mon_errors + 1;
            end
            else if (out_data !== prev_data || out_tag !== prev_tag)
            begin
               $display("Mismatch out_data held under back-pressure: expected %h/%h, got %h/%h",
                        prev_data, prev_tag, out_data, out_tag);
               mon_errors = mon_errors + 1;
            end
         end
         if (out_valid && !prev_valid)
         begin
            // Only words paced under the same gap setting are compared
            if (rise_epoch == gap_epoch && (cycle - last_rise) < min_gap)
            begin
               $display("test %0d: out_valid rose %0d cycles after the previous word, minimum %0d",
                        cur_test, cycle - last_rise, min_gap);
               mon_errors = mon_errors + 1;
            end
            last_rise  = cycle;
            rise_epoch = gap_epoch;
         end
         if (out_valid && out_ready)
         begin
            if (exp_q.size() == 0)
            begin
               $display("test %0d: unexpected output word %h", cur_test, out_data);
               mon_errors = mon_errors + 1;
            end
            else
            begin
               exp_word = exp_q.pop_front();
               if (out_data !== exp_word[35:4])
               begin
                  $display("Mismatch out_data: expected %h, got %h", exp_word[35:4], out_data);
                  mon_errors = mon_errors + 1;
               end
               if (out_tag !== exp_word[3:0])
               begin
                  $display("Mismatch out_tag: expected %h, got %h", exp_word[3:0], out_tag);
                  mon_errors = mon_errors + 1;
               end
            end
         end
         prev_valid = out_valid;
         prev_ready = out_ready;
         prev_data  = out_data;
         prev_tag   = out_tag;
      end
   end

   // One Wishbone classic cycle held until ack
   task automatic bus_cycle(input logic we, input logic [1:0] adr, input logic [31:0] dat,
                            output logic [31:0] rdata);
      wb_req_t req;
      int      k;
      logic    got;
      req     = '0;
      req.cyc = 1'b1;
      req.stb = 1'b1;
      req.we  = we;
      req.adr = adr;
      req.dat = dat;
      got     = 1'b0;
      rdata   = '0;
      @(posedge clk);
      bus_req <= req;
      for (k = 0; k < BUS_TIMEOUT && !got; k++)
      begin
         @(posedge clk);
         if (bus_rsp.ack)
         begin
            got   = 1'b1;
            rdata = bus_rsp.dat;
         end
      end
      bus_req <= '0;
      if (!got)
      begin
         $display("test %0d: no bus acknowledge within %0d cycles at address %0d",
                  cur_test, BUS_TIMEOUT, adr);
         errors = errors + 1;
         abort  = 1;
      end
   endtask

   task automatic push_words(input logic [31:0] data, input logic err, input int n);
      int i;
      for (i = 0; i < n; i++)
      begin
         @(posedge clk);
         in_valid <= 1'b1;
         in_data  <= data + 32'(i);
         in_err   <= err;
      end
      @(posedge clk);
      in_valid <= 1'b0;
   endtask

   task automatic run_command(input logic [7:0] c, input logic [31:0] a, input logic [31:0] b,
                              input int n);
      int          i;
      logic [31:0] rd;
      case (c)
         "W":
         begin
            for (i = 0; i < n && !abort; i++)
            begin
               bus_cycle(1'b1, a[1:0], b + 32'(i), rd);
            end
         end
         "R":
         begin
            for (i = 0; i < n && !abort; i++)
            begin
               bus_cycle(1'b0, a[1:0], 32'h0, rd);
               if (!abort && rd !== b + 32'(i))
               begin
                  $display("Mismatch bus_rsp.dat at address %0d: expected %h, got %h",
                           a[1:0], b + 32'(i), rd);
                  errors = errors + 1;
               end
            end
         end
         "S": push_words(a, b[0], n);
         "O":
         begin
            for (i = 0; i < n; i++)
            begin
               exp_q.push_back({a + 32'(i), 4'(b + 32'(i))});
            end
         end
         "G":
         begin
            min_gap   = int'(a);
            gap_epoch = gap_epoch + 1;
         end
         default:
         begin
            $display("test %0d: unknown command %c in the stimulus file", cur_test, c);
            errors = errors + 1;
         end
      endcase
   endtask

   // Waits for the expected words to drain, then reports the test
   task automatic finish_test();
      int k;
      for (k = 0; k < DRAIN_TIMEOUT && exp_q.size() != 0 && !abort; k++)
      begin
         @(posedge clk);
      end
      if (exp_q.size() != 0)
      begin
         $display("test %0d: %0d output words never arrived", cur_test, exp_q.size());
         errors = errors + 1;
         abort  = 1;
         exp_q.delete();
      end
      tests_run = tests_run + 1;
      if (errors + mon_errors == test_start_errors)
      begin
         $display("test %0d: pass", cur_test);
      end
      else
      begin
         tests_failed = tests_failed + 1;
         $display("test %0d: fail, %0d errors", cur_test,
                  errors + mon_errors - test_start_errors);
      end
   endtask

   initial
   begin
      seed         = 32'h68eb;
      errors       = 0;
      mon_errors   = 0;
      abort        = 0;
      cur_test     = -1;
      tests_run    = 0;
      tests_failed = 0;
      min_gap      = 0;
      gap_epoch    = 0;
      rst          = 1'b1;
      bus_req      = '0;
      in_valid     = 1'b0;
      in_data      = '0;
      in_err       = 1'b0;
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);

      fd = $fopen("tests/stream_input.txt", "r");
      if (fd == 0)
      begin
         $display("Cannot open the stimulus file tests/stream_input.txt");
         errors = errors + 1;
      end
      else
      begin
         while (!$feof(fd) && !abort)
         begin
            line = '0;
            code = $fgets(line, fd);
            // Comment and blank lines do not parse into five fields
            if (code > 0 &&
                $sscanf(line, "%d %c %h %h %d", tnum, cmd, arg_a, arg_b, count) == 5)
            begin
               if (tnum != cur_test)
               begin
                  if (cur_test >= 0)
                  begin
                     finish_test();
                  end
                  cur_test          = tnum;
                  test_start_errors = errors + mon_errors;
               end
               run_command(cmd, arg_a, arg_b, count);
            end
         end
         $fclose(fd);
         if (cur_test >= 0)
         begin
            finish_test();
         end
      end

      repeat (20) @(posedge clk);
      $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
               errors + mon_errors);
      if (errors + mon_errors == 0)
      begin
         $display("NO ERRORS");
      end
      else
      begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

// ==== tests/stream_input.txt ====
# test cmd a b count: W adr data, R adr expected, S data err, O data tag, G gap
# test and count are decimal, the rest hex; repeats step data and tag up by one
1 G 1 0 1
1 O 00001000 0 4
1 W 0 00001000 4
2 W 3 00000005 1
2 R 3 00000005 1
2 G 6 0 1
2 O 00002000 4 4
2 W 0 00002000 4
3 S 00003000 1 1
3 S 00003001 0 1
3 R 1 00003000 1
3 R 2 00000041 1
3 R 1 00003001 1
3 R 2 00000005 1
4 S 00004000 0 17
4 R 2 00000019 1
4 R 1 00004000 16
4 R 2 00000015 1
4 W 2 00000010 1
4 R 2 00000005 1
5 R 1 00000000 1
5 R 2 00000025 1
5 W 2 00000020 1
5 W 3 000000ff 1
5 G 100 0 1
5 O 00005000 8 17
5 W 0 00005000 18
5 R 2 00000016 1
6 R 2 00000015 1
6 W 2 00000010 1
6 R 2 00000005 1
6 W 3 00000000 1

// ==== compile.f ====
rtl/wb_stream_pkg.sv
rtl/sync_fifo.sv
rtl/pace_timer.sv
rtl/tx_drain.sv
rtl/wb_bus_fsm.sv
rtl/wb_stream_bridge.sv
tests/wb_stream_bridge_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --assert -j 0
TOP      = wb_stream_bridge_tb
FILELIST = compile.f
BUILD    = obj_dir
LOG      = sim.log
PASS     = NO ERRORS

.PHONY: sim clean

# The run passes only if the log holds the pass line
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS)$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
